// File: hw/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  soc_pkg::bus_req_t         req,
    output logic [63:0]               read_data,
    output logic                      read_done,
    input  logic [63:0]               fetch_addr,
    output logic [31:0]               instr,
    input  logic                      key_valid,
    input  logic [7:0]                key_ascii,
    input  logic                      irq_ack,
    output logic [soc_pkg::irq_w-1:0] irq_vector,
    output logic                      uart_write,
    output logic [31:0]               uart_data,
    output soc_pkg::sd_ctrl_t         sd_ctrl,
    input  soc_pkg::sd_stat_t         sd_stat
);
    import soc_pkg::*;

    bus_sel_t sel;
    bus_sel_t sel_q;      // region of the read in flight

    logic [data_w-1:0] ram_rdata;
    logic [data_w-1:0] sd_rdata;
    logic [data_w-1:0] key_rdata;
    logic [data_w-1:0] unit_rdata;
    logic [data_w-1:0] read_data_q;
    logic              ram_done;
    logic              unit_ready;
    logic              read_done_q;

    // address decode
    always_comb begin
        sel          = '0;
        sel.ram      = (req.addr - ram_base) < ram_size;
        sel.key      = req.addr == key_addr;
        sel.uart     = req.addr == uart_addr;
        sel.sd_addr  = req.addr == sd_addr_addr;
        sel.sd_read  = req.addr == sd_read_addr;
        sel.sd_ready = req.addr == sd_ready_addr;
        sel.sd_buf   = (req.addr - sd_buf_base) < addr_w'(sd_buf_bytes);
        sel.sd_avail = req.addr == sd_avail_addr;
    end

    word_ram u_word_ram (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .ram_sel    (sel.ram),
        .rdata      (ram_rdata),
        .done       (ram_done),
        .fetch_addr (fetch_addr),
        .instr      (instr)
    );

    sd_sector_buffer u_sd_sector_buffer (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (req),
        .sel      (sel),
        .ctrl     (sd_ctrl),
        .stat     (sd_stat),
        .rdata    (sd_rdata)
    );

    key_uart_regs u_key_uart_regs (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .sel        (sel),
        .key_valid  (key_valid),
        .key_ascii  (key_ascii),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .uart_write (uart_write),
        .uart_data  (uart_data),
        .rdata      (key_rdata)
    );

    // read data source by latched region
    always_comb begin
        if (sel_q.ram) begin
            unit_rdata = ram_rdata;
        end else if (sel_q.key) begin
            unit_rdata = key_rdata;
        end else if (sel_q.sd_buf || sel_q.sd_ready || sel_q.sd_avail) begin
            unit_rdata = sd_rdata;
        end else begin
            unit_rdata = '0;    // unmapped reads complete with zero
        end
    end

    // ram may need a second beat and the rest answer next cycle
    assign unit_ready = sel_q.ram ? ram_done : 1'b1;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_done_q <= 1'b1;
            sel_q       <= '0;
        end else if (req.rd) begin
            read_done_q <= 1'b0;
            sel_q       <= sel;
        end else if (!read_done_q && unit_ready) begin
            read_done_q <= 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (!read_done_q && unit_ready) read_data_q <= unit_rdata;
    end

    assign read_data = read_data_q;
    assign read_done = read_done_q;

    // cpu never reads and writes in one cycle
    a_rd_wr_excl : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(req.rd && req.wr));

endmodule

// File: hw/key_uart_regs.sv
`timescale 1ns/1ps

module key_uart_regs (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  soc_pkg::bus_req_t         req,
    input  soc_pkg::bus_sel_t         sel,
    input  logic                      key_valid,
    input  logic [7:0]                key_ascii,
    input  logic                      irq_ack,
    output logic [soc_pkg::irq_w-1:0] irq_vector,
    output logic                      uart_write,
    output logic [31:0]               uart_data,
    output logic [63:0]               rdata
);
    import soc_pkg::*;

    logic [7:0]        ascii_q;     // last key code
    logic [irq_w-1:0]  irq_q;
    logic              uart_trig;
    logic              uart_trig_d;
    logic [data_w-1:0] rdata_q;

    always_ff @(posedge CLOCK_50) begin
        if (key_valid) ascii_q <= key_ascii;
    end

    // interrupt request held until acknowledged
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_q <= '0;
        end else if (irq_ack) begin
            irq_q <= '0;                                  // ack beats a new key
        end else if (key_valid && key_ascii != 8'd0) begin
            irq_q <= irq_key;
        end
    end

    assign irq_vector = irq_q;

    // console strobe edge detect
    assign uart_trig = req.wr && sel.uart;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) uart_trig_d <= 1'b0;
        else       uart_trig_d <= uart_trig;
    end

    assign uart_write = uart_trig && !uart_trig_d;
    assign uart_data  = req.wdata[word_w-1:0];    // console takes the low word

    // keyboard register read
    always_ff @(posedge CLOCK_50) begin
        if (req.rd && sel.key) rdata_q <= {{(data_w - 8){1'b0}}, ascii_q};
    end

    assign rdata = rdata_q;

endmodule

// File: hw/sd_sector_buffer.sv
`timescale 1ns/1ps

module sd_sector_buffer (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  soc_pkg::bus_req_t req,
    input  soc_pkg::bus_sel_t sel,
    output soc_pkg::sd_ctrl_t ctrl,
    input  soc_pkg::sd_stat_t stat,
    output logic [63:0]       rdata
);
    import soc_pkg::*;

    logic [7:0] rx_buf [sd_buf_bytes];   // one sector

    logic [sector_w-1:0] sector_q;
    logic                rd_start_q;
    logic [sd_idx_w-1:0] rx_idx;          // next byte slot
    logic                avail_q;
    logic                valid_d;         // byte_valid delayed for edge detect
    logic [data_w-1:0]   rdata_q;

    logic [addr_w-1:0] buf_off;
    logic              byte_edge;

    assign buf_off   = req.addr - sd_buf_base;
    assign byte_edge = stat.byte_valid && !valid_d;

    // controller side registers
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sector_q   <= '0;
            rd_start_q <= 1'b0;
        end else begin
            rd_start_q <= req.wr && sel.sd_read;   // one pulse per write strobe
            if (req.wr && sel.sd_addr) sector_q <= req.wdata[sector_w-1:0];
        end
    end

    assign ctrl = '{sector: sector_q, rd_start: rd_start_q};

    // receive index and availability
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rx_idx  <= '0;
            avail_q <= 1'b0;
            valid_d <= 1'b0;
        end else begin
            valid_d <= stat.byte_valid;
            if (byte_edge) begin
                rx_idx <= rx_idx + 1'b1;                   // wraps after byte 511
                if (rx_idx == sd_idx_w'(sd_buf_bytes - 1)) avail_q <= 1'b1;
            end
            // a new sector is well under way
            if (rx_idx == sd_idx_w'(sd_avail_clear_idx)) avail_q <= 1'b0;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (byte_edge) rx_buf[rx_idx] <= stat.rx_byte;
    end

    // read data one cycle after the strobe
    always_ff @(posedge CLOCK_50) begin
        if (req.rd) begin
            if (sel.sd_buf) begin
                rdata_q <= {{(data_w - 8){1'b0}}, rx_buf[buf_off[sd_idx_w-1:0]]};  // byte per load
            end else if (sel.sd_ready) begin
                rdata_q <= {{(data_w - 1){1'b0}}, stat.ready};
            end else if (sel.sd_avail) begin
                rdata_q <= {{(data_w - 1){1'b0}}, avail_q};
            end
        end
    end

    assign rdata = rdata_q;

    // controller expects a single-cycle start
    a_rd_start_pulse : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ctrl.rd_start |=> !ctrl.rd_start);

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

    // bus geometry
    localparam int addr_w     = 64;
    localparam int data_w     = 64;
    localparam int word_w     = 32;
    localparam int word_bytes = word_w / 8;

    // word memory
    localparam int mem_words = 3072;               // 12 KiB of 32-bit words
    localparam int ram_idx_w = $clog2(mem_words);

    localparam logic [addr_w-1:0] ram_base = 64'h0;
    localparam logic [addr_w-1:0] ram_size = 64'd12288;

    // single-register peripherals
    localparam logic [addr_w-1:0] key_addr      = 64'h1_0000;
    localparam logic [addr_w-1:0] uart_addr     = 64'h1_0008;
    localparam logic [addr_w-1:0] sd_addr_addr  = 64'h1_0010;   // sector number
    localparam logic [addr_w-1:0] sd_read_addr  = 64'h1_0018;   // write starts a read
    localparam logic [addr_w-1:0] sd_ready_addr = 64'h1_0020;
    localparam logic [addr_w-1:0] sd_avail_addr = 64'h1_0028;

    // sd receive buffer
    localparam logic [addr_w-1:0] sd_buf_base = 64'h1_1000;
    localparam int sd_buf_bytes       = 512;
    localparam int sd_idx_w           = $clog2(sd_buf_bytes);
    localparam int sd_avail_clear_idx = 10;        // flag drops this far into the next sector
    localparam int sector_w           = 32;

    // interrupt vector
    localparam int irq_w = 4;
    localparam logic [irq_w-1:0] irq_key = 4'd1;

    // load/store size code, bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        acc_byte   = 3'b000,
        acc_half   = 3'b001,
        acc_word   = 3'b010,
        acc_double = 3'b011,
        acc_byte_u = 3'b100,
        acc_half_u = 3'b101,
        acc_word_u = 3'b110
    } access_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              rd;       // one-cycle strobe
        logic              wr;       // one-cycle strobe
        access_t           rd_type;
        access_t           wr_type;
    } bus_req_t;

    // one-hot region decode
    typedef struct packed {
        logic ram;
        logic key;
        logic uart;
        logic sd_addr;
        logic sd_read;
        logic sd_ready;
        logic sd_buf;
        logic sd_avail;
    } bus_sel_t;

    typedef struct packed {
        logic [sector_w-1:0] sector;
        logic                rd_start;
    } sd_ctrl_t;

    typedef struct packed {
        logic       ready;
        logic       byte_valid;
        logic [7:0] rx_byte;     // received data byte
    } sd_stat_t;

endpackage

// File: hw/word_ram.sv
`timescale 1ns/1ps

module word_ram (
    input  logic             CLOCK_50,
    input  logic             KEY0,
    input  soc_pkg::bus_req_t req,
    input  logic             ram_sel,
    output logic [63:0]      rdata,
    output logic             done,
    input  logic [63:0]      fetch_addr,
    output logic [31:0]      instr
);
    import soc_pkg::*;

    // byte lanes so sized stores map onto write enables
    logic [word_bytes-1:0][7:0] mem [mem_words];

    logic [word_bytes-1:0][7:0] mem_q;      // port b read word
    logic [word_bytes-1:0][7:0] fetch_q;    // port a read word
    logic [word_w-1:0]          lo_q;       // first beat of a double load
    logic [1:0]                 off_q;      // byte offset of the load
    logic                       dbl_q;

    logic beat_q;       // second beat of a double in progress
    logic beat_wr_q;    // that beat belongs to a store
    logic done_q;

    logic [addr_w-1:0]          ram_off;
    logic [addr_w-1:0]          fetch_off;
    logic [ram_idx_w-1:0]       acc_idx;
    logic [1:0]                 byte_off;
    logic [word_bytes-1:0]      wr_be;
    logic [word_bytes-1:0][7:0] wr_word;
    logic                       rd_hit;
    logic                       wr_hit;

    assign ram_off   = req.addr - ram_base;
    assign fetch_off = fetch_addr - ram_base;
    assign byte_off  = ram_off[1:0];
    assign acc_idx   = ram_off[ram_idx_w+1:2] + ram_idx_w'(beat_q);  // next word on beat 2

    assign rd_hit = ram_sel && req.rd;
    assign wr_hit = ram_sel && req.wr;

    // store merge
    always_comb begin
        wr_be   = '0;
        wr_word = req.wdata[word_w-1:0];
        if (beat_q) begin
            wr_be   = beat_wr_q ? '1 : '0;         // high word of a double store
            wr_word = req.wdata[data_w-1:word_w];
        end else if (wr_hit) begin
            case (req.wr_type)
                acc_byte: begin
                    wr_be   = word_bytes'(1) << byte_off;
                    wr_word = {word_bytes{req.wdata[7:0]}};
                end
                acc_half: begin
                    // halves only land on offsets 0 and 2
                    wr_be   = byte_off[0] ? '0 : (word_bytes'(3) << byte_off);
                    wr_word = {(word_bytes / 2){req.wdata[15:0]}};
                end
                acc_word,
                acc_double: wr_be = '1;           // double low word goes first
                default: wr_be = '0;              // unsigned codes are loads only
            endcase
        end
    end

    // port b read/write
    always_ff @(posedge CLOCK_50) begin
        for (int b = 0; b < word_bytes; b++) begin
            if (wr_be[b]) mem[acc_idx][b] <= wr_word[b];
        end
        mem_q <= mem[acc_idx];
    end

    // port a instruction fetch
    always_ff @(posedge CLOCK_50) begin
        fetch_q <= mem[fetch_off[ram_idx_w+1:2]];
    end

    assign instr = {fetch_q[0], fetch_q[1], fetch_q[2], fetch_q[3]};  // endian swap

    // beat sequencing and done pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat_q    <= 1'b0;
            beat_wr_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (beat_q) begin
                beat_q <= 1'b0;
                done_q <= !beat_wr_q;                 // double load finishes here
            end else if (rd_hit) begin
                beat_q    <= req.rd_type == acc_double;
                beat_wr_q <= 1'b0;
                done_q    <= req.rd_type != acc_double;
            end else if (wr_hit && req.wr_type == acc_double) begin
                beat_q    <= 1'b1;
                beat_wr_q <= 1'b1;
            end
        end
    end

    // load context
    always_ff @(posedge CLOCK_50) begin
        if (rd_hit) begin
            off_q <= byte_off;
            dbl_q <= req.rd_type == acc_double;
        end
        if (beat_q) lo_q <= mem_q;    // word 0 of the double
    end

    // zero-extended shift for single beats
    assign rdata = dbl_q ? {mem_q, lo_q}
                         : {{(data_w - word_w){1'b0}}, word_w'(mem_q >> {off_q, 3'b000})};
    assign done  = done_q;

    // cpu only issues doubles on 8-byte boundaries
    a_dbl_aligned : assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (ram_sel && ((req.rd && req.rd_type == acc_double) ||
                     (req.wr && req.wr_type == acc_double)))
        |-> req.addr[2:0] == 3'b000);

endmodule

// File: project.f
+incdir+sim
hw/soc_pkg.sv
hw/word_ram.sv
hw/sd_sector_buffer.sv
hw/key_uart_regs.sv
hw/bus_fabric.sv
sim/tb_bus_fabric.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_fabric \
    -f project.f -Mdir obj_dir > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_bus_fabric > sim.log 2>&1 ; cat sim.log
grep -q "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sim/tb_ref.svh
logic [31:0] rng_state = 32'd6876;        // lcg seed
logic [31:0] shadow_mem [mem_words];      // expected ram words
logic [7:0]  shadow_sd [sd_buf_bytes];    // expected receive buffer

function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state ^ (rng_state >> 15);    // fold high bits down
endfunction

function automatic int rand_below(int n);
    return int'(next_rand() % 32'(n));
endfunction

// initial ram contents depend on every address bit
function automatic logic [31:0] fill_word(int idx);
    return (32'(idx) * 32'h9e37_79b1) ^ {idx[15:0], 16'hc3a5};
endfunction

// sized store into one word
function automatic logic [31:0] store_merge(logic [31:0] old, logic [63:0] data,
                                            access_t code, logic [1:0] off);
    logic [31:0] w;
    w = old;
    case (code)
        acc_byte: w[8*off +: 8] = data[7:0];
        acc_half: w[8*off +: 16] = data[15:0];   // offset 0 or 2 only
        default:  w = data[31:0];                // word or low beat of a double
    endcase
    return w;
endfunction

// single beat is the word shifted down and zero-extended
function automatic logic [63:0] load_result(logic [31:0] word, logic [1:0] off);
    logic [31:0] s;
    s = word >> (8 * off);
    return {32'd0, s};
endfunction

function automatic logic [31:0] fetch_swap(logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};   // byte order reversed
endfunction

// File: sim/tb_bus_fabric.sv
`timescale 1ns/1ps

module tb_bus_fabric;
    import soc_pkg::*;

    localparam int n_single = 200;    // store plus six loads each
    localparam int n_double = 100;
    localparam int n_fetch  = 200;
    localparam int n_sd_rd  = 32;
    // twice the cycles of all tests
    localparam int max_cycles = 2 * (mem_words + 20 * n_single + 8 * n_double + 2 * n_fetch
                                     + 3 * (sd_buf_bytes + 10) + 4 * n_sd_rd + 400);

    logic             CLOCK_50;
    logic             KEY0;
    bus_req_t         req;
    logic [63:0]      read_data;
    logic             read_done;
    logic [63:0]      fetch_addr;
    logic [31:0]      instr;
    logic             key_valid;
    logic [7:0]       key_ascii;
    logic             irq_ack;
    logic [irq_w-1:0] irq_vector;
    logic             uart_write;
    logic [31:0]      uart_data;
    sd_ctrl_t         sd_ctrl;
    sd_stat_t         sd_stat;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          uart_pulses = 0;
    int          start_pulses = 0;
    logic [31:0] uart_seen;
    logic        done_d = 1'b1;
    logic [63:0] exp_q [$];     // expected read data in issue order
    string       name_q [$];
    access_t     load_codes [6] = '{acc_byte, acc_half, acc_word,
                                    acc_byte_u, acc_half_u, acc_word_u};

    `include "tb_ref.svh"

    bus_fabric i_dut (.*);    // tb signals carry the port names

    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    // a double holds addr and data for beat two
    task automatic bus_write(logic [63:0] addr, logic [63:0] data, access_t code);
        req.addr    = addr;
        req.wdata   = data;
        req.wr_type = code;
        req.wr      = 1'b1;
        @(posedge CLOCK_50);
        #1 req.wr = 1'b0;
        if (code == acc_double) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    task automatic bus_read(logic [63:0] addr, access_t code, logic [63:0] exp, string name);
        exp_q.push_back(exp);     // compare process picks it up
        name_q.push_back(name);
        req.addr    = addr;
        req.rd_type = code;
        req.rd      = 1'b1;
        @(posedge CLOCK_50);
        #1 req.rd = 1'b0;
        if (read_done) note_failure("read_done did not fall after a read strobe");
        while (!read_done) begin
            @(posedge CLOCK_50);
            #1;
        end
    endtask

    // compare each completed read and count strobe pulses
    always @(negedge CLOCK_50) begin
        if (read_done && !done_d) begin
            if (exp_q.size() == 0) note_failure("read_done rose with no read pending");
            else check(name_q.pop_front(), read_data, exp_q.pop_front());
        end
        done_d = read_done;
        if (uart_write) begin
            uart_pulses++;
            uart_seen = uart_data;
        end
        if (sd_ctrl.rd_start) start_pulses++;
    end

    function automatic int legal_offset(access_t code);
        case (code[1:0])
            2'b00:   return rand_below(4);        // bytes anywhere
            2'b01:   return 2 * rand_below(2);
            default: return 0;
        endcase
    endfunction

    task automatic sized_access();
        int          idx;
        int          off;
        logic [63:0] data;
        access_t     code;
        for (int i = 0; i < mem_words; i++) begin    // whole ram gets a known value
            shadow_mem[i] = fill_word(i);
            bus_write(64'(i * 4), {32'd0, shadow_mem[i]}, acc_word);
        end
        for (int n = 0; n < n_single; n++) begin
            idx  = rand_below(mem_words);
            data = {next_rand(), next_rand()};
            code = access_t'(rand_below(3));         // byte, half or word
            off  = legal_offset(code);
            shadow_mem[idx] = store_merge(shadow_mem[idx], data, code, 2'(off));
            bus_write(64'(idx * 4 + off), data, code);
            foreach (load_codes[k]) begin
                off = legal_offset(load_codes[k]);
                bus_read(64'(idx * 4 + off), load_codes[k],
                         load_result(shadow_mem[idx], 2'(off)), "read_data load");
            end
        end
    endtask

    task automatic double_and_fetch();
        int          idx;
        logic [63:0] data;
        for (int n = 0; n < n_double; n++) begin
            idx  = 2 * rand_below(mem_words / 2);    // 8-byte aligned
            data = {next_rand(), next_rand()};
            shadow_mem[idx]     = data[31:0];
            shadow_mem[idx + 1] = data[63:32];
            bus_write(64'(idx * 4), data, acc_double);
            bus_read(64'(idx * 4), acc_double, data, "read_data double");
        end
        for (int n = 0; n < n_fetch; n++) begin
            idx        = rand_below(mem_words);
            fetch_addr = 64'(idx * 4);
            @(posedge CLOCK_50);
            #1 check("instr", 64'(instr), 64'(fetch_swap(shadow_mem[idx])));
        end
    endtask

    task automatic keyboard_irq();
        logic [7:0] code;
        code      = 8'(rand_below(255) + 1);    // nonzero
        key_ascii = code;
        key_valid = 1'b1;
        @(posedge CLOCK_50);
        #1 key_valid = 1'b0;
        bus_read(key_addr, acc_byte_u, 64'(code), "read_data key");
        check("irq_vector", 64'(irq_vector), 64'(irq_key));   // held until ack
        irq_ack = 1'b1;
        @(posedge CLOCK_50);
        #1 irq_ack = 1'b0;
        check("irq_vector", 64'(irq_vector), 64'd0);
        key_ascii = 8'd0;
        key_valid = 1'b1;
        @(posedge CLOCK_50);
        #1 key_valid = 1'b0;
        check("irq_vector", 64'(irq_vector), 64'd0);          // zero code raises no irq
        bus_read(key_addr, acc_byte_u, 64'd0, "read_data key");
        key_ascii = code;
        key_valid = 1'b1;
        irq_ack   = 1'b1;
        @(posedge CLOCK_50);
        #1 key_valid = 1'b0;
        irq_ack = 1'b0;
        check("irq_vector", 64'(irq_vector), 64'd0);          // ack wins over a new key
    endtask

    task automatic console_and_sd();
        logic [63:0] data;
        data = {next_rand(), next_rand()};
        bus_write(uart_addr, data, acc_word);
        repeat (3) @(posedge CLOCK_50);
        #1 check("uart_write pulses", 64'(uart_pulses), 64'd1);
        check("uart_data", 64'(uart_seen), 64'(data[31:0]));
        bus_write(sd_addr_addr, data, acc_word);
        check("sd_ctrl.sector", 64'(sd_ctrl.sector), 64'(data[31:0]));
        bus_write(sd_read_addr, 64'd0, acc_word);
        repeat (3) @(posedge CLOCK_50);
        #1 check("sd_ctrl.rd_start pulses", 64'(start_pulses), 64'd1);
        bus_read(64'h2_0000, acc_word, 64'd0, "read_data unmapped");
        bus_read(ram_size, acc_word, 64'd0, "read_data unmapped");   // just past ram
    endtask

    task automatic feed_byte(logic [7:0] b);
        sd_stat.rx_byte    = b;
        sd_stat.byte_valid = 1'b1;
        repeat (2) @(posedge CLOCK_50);    // level held past the edge
        #1 sd_stat.byte_valid = 1'b0;
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic sector_receive();
        int off;
        for (int i = 0; i < sd_buf_bytes; i++) begin
            shadow_sd[i] = 8'(next_rand());
            feed_byte(shadow_sd[i]);
        end
        bus_read(sd_avail_addr, acc_word, 64'd1, "read_data sd_avail");
        for (int n = 0; n < n_sd_rd; n++) begin
            off = rand_below(sd_buf_bytes);
            bus_read(sd_buf_base + 64'(off), acc_byte_u, 64'(shadow_sd[off]), "read_data sd_buf");
        end
        sd_stat.ready = 1'b1;
        bus_read(sd_ready_addr, acc_word, 64'd1, "read_data sd_ready");
        sd_stat.ready = 1'b0;
        bus_read(sd_ready_addr, acc_word, 64'd0, "read_data sd_ready");
        for (int i = 0; i < sd_avail_clear_idx - 1; i++) feed_byte(8'(next_rand()));
        bus_read(sd_avail_addr, acc_word, 64'd1, "read_data sd_avail");   // still set
        feed_byte(8'(next_rand()));
        bus_read(sd_avail_addr, acc_word, 64'd0, "read_data sd_avail");   // next sector begun
    endtask

    initial begin
        KEY0       = 1'b0;
        req        = '0;
        fetch_addr = '0;
        key_valid  = 1'b0;
        key_ascii  = 8'd0;
        irq_ack    = 1'b0;
        sd_stat    = '0;
        repeat (5) @(posedge CLOCK_50);
        #1 KEY0 = 1'b1;
        check("read_done", 64'(read_done), 64'd1);    // idle state out of reset
        check("uart_write", 64'(uart_write), 64'd0);
        check("sd_ctrl.rd_start", 64'(sd_ctrl.rd_start), 64'd0);
        check("irq_vector", 64'(irq_vector), 64'd0);
        sized_access();
        double_and_fetch();
        keyboard_irq();
        console_and_sd();
        sector_receive();
        repeat (4) @(posedge CLOCK_50);
        if (exp_q.size() != 0) note_failure("a read never completed");
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    always @(posedge CLOCK_50) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("run stopped at %0d cycles, checks %0d errors %0d", cycles, checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule
